/* hw/bster_pkg.sv */
// ----------------------------------------------------------------------
// Shared definitions of the tree insert engine: node fields and layout,
// command codes and controller states
// ----------------------------------------------------------------------

package bster_pkg;

    localparam int TOKEN_WIDTH   = 8;
    localparam int PAYLOAD_WIDTH = 16;
    localparam int ADDR_WIDTH    = 8;
    localparam int INFO_WIDTH    = 8;
    localparam int NODE_WIDTH    = PAYLOAD_WIDTH + 3 * ADDR_WIDTH + TOKEN_WIDTH + INFO_WIDTH;

    typedef logic [TOKEN_WIDTH-1:0]   token_t;
    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [INFO_WIDTH-1:0]    info_t;
    // Payload, left, right, parent, token, info from MSB down
    typedef logic [NODE_WIDTH-1:0]    node_t;

    localparam addr_t ROOT_ADDR = '0;

    // Bit positions in the info field
    localparam int INFO_ROOT      = 3;
    localparam int INFO_IS_LEFT   = 2;
    localparam int INFO_HAS_LEFT  = 1;
    localparam int INFO_HAS_RIGHT = 0;

    typedef logic [7:0] cmd_t;
    localparam cmd_t CMD_INSERT_TOKEN = 8'h01;

    // Node word selection for a write
    localparam logic [1:0] BUILD_ROOT   = 2'd0;
    localparam logic [1:0] BUILD_PARENT = 2'd1;
    localparam logic [1:0] BUILD_CHILD  = 2'd2;

    typedef enum logic [2:0] {
        IDLE,
        INSERT,
        SEARCH,
        WR_RAM,
        RD_RAM,
        WAIT_RD,
        COMPLETE
    } ctrl_state_t;

endpackage

/* hw/node_mem_if.sv */
// ----------------------------------------------------------------------
// Node access channel between the insert controller and the memory port
// ----------------------------------------------------------------------

`timescale 1ns/100ps

interface node_mem_if;

    // Held by the controller until done
    logic               req;
    logic               wr;
    bster_pkg::addr_t   addr;
    bster_pkg::node_t   wdata;

    // One-cycle end of access, read data stays valid afterwards
    logic               done;
    bster_pkg::node_t   rdata;

    modport ctrl (
        output req, wr, addr, wdata,
        input  done, rdata
    );

    modport port (
        input  req, wr, addr, wdata,
        output done, rdata
    );

endinterface

/* hw/node_alloc.sv */
// ----------------------------------------------------------------------
// Node allocator: hands out addresses in order and tracks occupancy
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module node_alloc #(
    parameter int unsigned MAX_NODES = 16
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              tree_emptied,
    input  logic              commit,
    output logic              tree_ready,
    output bster_pkg::addr_t  alloc_addr,
    output logic              full
);

    // One bit wider so a full address space can be counted
    localparam int CNT_WIDTH = bster_pkg::ADDR_WIDTH + 1;

    logic [CNT_WIDTH-1:0] count;

    assign tree_ready = (count != '0);
    assign alloc_addr = count[bster_pkg::ADDR_WIDTH-1:0];
    assign full       = (count == CNT_WIDTH'(MAX_NODES));

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else if (tree_emptied) begin
            count <= '0;
        end else if (commit) begin
            count <= count + 1'b1;
        end
    end

endmodule

/* hw/node_format.sv */
// ----------------------------------------------------------------------
// Node formatter: splits a read node into fields and builds the root,
// parent-update and child words
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module node_format (
    input  bster_pkg::node_t     rdata,
    input  logic [1:0]           build_sel,
    input  logic                 slot_right,
    input  bster_pkg::addr_t     parent_addr,
    input  bster_pkg::token_t    token_q,
    input  bster_pkg::payload_t  data_q,
    input  bster_pkg::addr_t     new_addr,
    output bster_pkg::node_t     node_word,
    output bster_pkg::token_t    rd_token,
    output bster_pkg::addr_t     rd_left,
    output bster_pkg::addr_t     rd_right,
    output logic                 rd_has_left,
    output logic                 rd_has_right
);

    bster_pkg::payload_t rd_payload;
    bster_pkg::addr_t    rd_parent;
    bster_pkg::info_t    rd_info;
    bster_pkg::info_t    upd_info;
    bster_pkg::info_t    new_info;

    assign {rd_payload, rd_left, rd_right, rd_parent, rd_token, rd_info} = rdata;

    assign rd_has_left  = rd_info[bster_pkg::INFO_HAS_LEFT];
    assign rd_has_right = rd_info[bster_pkg::INFO_HAS_RIGHT];

    always_comb begin
        // Parent keeps its flags and gains one child
        upd_info = rd_info;
        if (slot_right) begin
            upd_info[bster_pkg::INFO_HAS_RIGHT] = 1'b1;
        end else begin
            upd_info[bster_pkg::INFO_HAS_LEFT] = 1'b1;
        end

        new_info = '0;
        case (build_sel)
            bster_pkg::BUILD_ROOT: begin
                new_info[bster_pkg::INFO_ROOT] = 1'b1;
                node_word = {data_q, bster_pkg::addr_t'(0), bster_pkg::addr_t'(0),
                             bster_pkg::ROOT_ADDR, token_q, new_info};
            end
            bster_pkg::BUILD_PARENT: begin
                node_word = {rd_payload,
                             slot_right ? rd_left : new_addr,
                             slot_right ? new_addr : rd_right,
                             rd_parent, rd_token, upd_info};
            end
            default: begin
                new_info[bster_pkg::INFO_IS_LEFT] = !slot_right;
                node_word = {data_q, bster_pkg::addr_t'(0), bster_pkg::addr_t'(0),
                             parent_addr, token_q, new_info};
            end
        endcase
    end

endmodule

/* hw/node_mem_port.sv */
// ----------------------------------------------------------------------
// Memory port: turns node accesses into the external RAM handshake and
// keeps the last read node
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module node_mem_port (
    input  logic              aclk,
    input  logic              aresetn,
    node_mem_if.port          mem,
    output logic              mem_valid,
    input  logic              mem_ready,
    output logic              mem_wr,
    output logic              mem_rd,
    output bster_pkg::addr_t  mem_addr,
    output bster_pkg::node_t  mem_wr_data,
    input  logic              mem_rd_valid,
    output logic              mem_rd_ready,
    input  bster_pkg::node_t  mem_rd_data
);

    // Set once the RAM took the request, cleared with done
    logic             held;
    logic             rd_wait;
    logic             done_q;
    bster_pkg::node_t rdata_q;

    assign mem_valid    = mem.req && !held;
    assign mem_wr       = mem_valid && mem.wr;
    assign mem_rd       = mem_valid && !mem.wr;
    assign mem_addr     = mem.addr;
    assign mem_wr_data  = mem.wdata;
    assign mem_rd_ready = rd_wait;

    assign mem.done  = done_q;
    assign mem.rdata = rdata_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            held    <= 1'b0;
            rd_wait <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (done_q) begin
                held <= 1'b0;
            end
            if (mem_valid && mem_ready) begin
                held <= 1'b1;
                if (mem.wr) begin
                    done_q <= 1'b1;
                end else begin
                    rd_wait <= 1'b1;
                end
            end
            if (rd_wait && mem_rd_valid) begin
                rd_wait <= 1'b0;
                done_q  <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_wait && mem_rd_valid) begin
            rdata_q <= mem_rd_data;
        end
    end

endmodule

/* hw/insert_ctrl.sv */
// ----------------------------------------------------------------------
// Insert controller: walks the tree from the root, links the new node
// into its parent and writes it, one memory access at a time
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module insert_ctrl (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  bster_pkg::cmd_t      req_cmd,
    input  bster_pkg::token_t    req_token,
    input  bster_pkg::payload_t  req_data,
    output logic                 cpl_valid,
    input  logic                 cpl_ready,
    output logic                 cpl_status,
    node_mem_if.ctrl             mem,
    input  logic                 tree_ready,
    input  logic                 alloc_full,
    input  bster_pkg::addr_t     alloc_addr,
    output logic                 alloc_commit,
    input  bster_pkg::token_t    rd_token,
    input  bster_pkg::addr_t     rd_left,
    input  bster_pkg::addr_t     rd_right,
    input  logic                 rd_has_left,
    input  logic                 rd_has_right,
    output logic                 slot_right,
    output logic [1:0]           build_sel,
    output bster_pkg::addr_t     parent_addr,
    output bster_pkg::token_t    token_q,
    output bster_pkg::payload_t  data_q,
    input  bster_pkg::node_t     node_word
);

    bster_pkg::ctrl_state_t state;
    // State to resume once the memory access ends
    bster_pkg::ctrl_state_t ret_state;
    bster_pkg::addr_t       addr_q;
    logic                   found;
    logic                   parent_written;
    logic                   accept;

    assign req_ready = (state == bster_pkg::IDLE);
    assign accept    = req_valid && req_ready;
    assign cpl_valid = (state == bster_pkg::COMPLETE);

    assign mem.req   = (state == bster_pkg::WR_RAM) || (state == bster_pkg::RD_RAM);
    assign mem.wr    = (state == bster_pkg::WR_RAM);
    assign mem.addr  = addr_q;
    assign mem.wdata = node_word;

    // Root and child writes both return to COMPLETE
    assign alloc_commit = (state == bster_pkg::WR_RAM) && mem.done &&
                          (ret_state == bster_pkg::COMPLETE);

    always_ff @(posedge aclk) begin
        if (accept) begin
            token_q <= req_token;
            data_q  <= req_data;
        end
    end

    // ------------------------------------------------------------------
    // Main FSM
    // ------------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state          <= bster_pkg::IDLE;
            ret_state      <= bster_pkg::IDLE;
            addr_q         <= bster_pkg::ROOT_ADDR;
            parent_addr    <= bster_pkg::ROOT_ADDR;
            found          <= 1'b0;
            parent_written <= 1'b0;
            slot_right     <= 1'b0;
            build_sel      <= bster_pkg::BUILD_ROOT;
            cpl_status     <= 1'b0;
        end else begin
            case (state)
                bster_pkg::IDLE: begin
                    if (accept) begin
                        found          <= 1'b0;
                        parent_written <= 1'b0;
                        if (req_cmd == bster_pkg::CMD_INSERT_TOKEN && !alloc_full) begin
                            cpl_status <= 1'b0;
                            state      <= bster_pkg::INSERT;
                        end else begin
                            cpl_status <= 1'b1;
                            state      <= bster_pkg::COMPLETE;
                        end
                    end
                end
                bster_pkg::INSERT: begin
                    if (!tree_ready) begin
                        build_sel <= bster_pkg::BUILD_ROOT;
                        addr_q    <= bster_pkg::ROOT_ADDR;
                        ret_state <= bster_pkg::COMPLETE;
                        state     <= bster_pkg::WR_RAM;
                    end else if (found && !parent_written) begin
                        // Parent fields are still in the read buffer
                        build_sel      <= bster_pkg::BUILD_PARENT;
                        addr_q         <= parent_addr;
                        parent_written <= 1'b1;
                        ret_state      <= bster_pkg::INSERT;
                        state          <= bster_pkg::WR_RAM;
                    end else if (found) begin
                        build_sel <= bster_pkg::BUILD_CHILD;
                        addr_q    <= alloc_addr;
                        ret_state <= bster_pkg::COMPLETE;
                        state     <= bster_pkg::WR_RAM;
                    end else begin
                        addr_q    <= bster_pkg::ROOT_ADDR;
                        ret_state <= bster_pkg::SEARCH;
                        state     <= bster_pkg::RD_RAM;
                    end
                end
                bster_pkg::SEARCH: begin
                    // Equal tokens go left
                    if (token_q <= rd_token) begin
                        if (rd_has_left) begin
                            addr_q <= rd_left;
                            state  <= bster_pkg::RD_RAM;
                        end else begin
                            found       <= 1'b1;
                            slot_right  <= 1'b0;
                            parent_addr <= addr_q;
                            state       <= bster_pkg::INSERT;
                        end
                    end else if (rd_has_right) begin
                        addr_q <= rd_right;
                        state  <= bster_pkg::RD_RAM;
                    end else begin
                        found       <= 1'b1;
                        slot_right  <= 1'b1;
                        parent_addr <= addr_q;
                        state       <= bster_pkg::INSERT;
                    end
                end
                bster_pkg::WR_RAM: begin
                    if (mem.done) begin
                        state <= ret_state;
                    end
                end
                bster_pkg::RD_RAM: begin
                    if (mem.done) begin
                        state <= bster_pkg::WAIT_RD;
                    end
                end
                // Turnaround before the read fields are compared
                bster_pkg::WAIT_RD: begin
                    state <= ret_state;
                end
                bster_pkg::COMPLETE: begin
                    if (cpl_ready) begin
                        state <= bster_pkg::IDLE;
                    end
                end
                default: begin
                    state <= bster_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/bster_insert_top.sv */
// ----------------------------------------------------------------------
// Tree insert engine top level
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module bster_insert_top #(
    parameter int unsigned MAX_NODES = 16
) (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  bster_pkg::cmd_t      req_cmd,
    input  bster_pkg::token_t    req_token,
    input  bster_pkg::payload_t  req_data,
    output logic                 cpl_valid,
    input  logic                 cpl_ready,
    output logic                 cpl_status,
    input  logic                 tree_emptied,
    output logic                 mem_valid,
    input  logic                 mem_ready,
    output logic                 mem_wr,
    output logic                 mem_rd,
    output bster_pkg::addr_t     mem_addr,
    output bster_pkg::node_t     mem_wr_data,
    input  logic                 mem_rd_valid,
    output logic                 mem_rd_ready,
    input  bster_pkg::node_t     mem_rd_data
);

    logic                tree_ready;
    logic                alloc_full;
    logic                alloc_commit;
    bster_pkg::addr_t    alloc_addr;
    bster_pkg::token_t   rd_token;
    bster_pkg::addr_t    rd_left;
    bster_pkg::addr_t    rd_right;
    logic                rd_has_left;
    logic                rd_has_right;
    logic                slot_right;
    logic [1:0]          build_sel;
    bster_pkg::addr_t    parent_addr;
    bster_pkg::token_t   token_q;
    bster_pkg::payload_t data_q;
    bster_pkg::node_t    node_word;

    node_mem_if mem_if ();

    insert_ctrl u_ctrl (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_cmd      (req_cmd),
        .req_token    (req_token),
        .req_data     (req_data),
        .cpl_valid    (cpl_valid),
        .cpl_ready    (cpl_ready),
        .cpl_status   (cpl_status),
        .mem          (mem_if.ctrl),
        .tree_ready   (tree_ready),
        .alloc_full   (alloc_full),
        .alloc_addr   (alloc_addr),
        .alloc_commit (alloc_commit),
        .rd_token     (rd_token),
        .rd_left      (rd_left),
        .rd_right     (rd_right),
        .rd_has_left  (rd_has_left),
        .rd_has_right (rd_has_right),
        .slot_right   (slot_right),
        .build_sel    (build_sel),
        .parent_addr  (parent_addr),
        .token_q      (token_q),
        .data_q       (data_q),
        .node_word    (node_word)
    );

    node_format u_format (
        .rdata        (mem_if.rdata),
        .build_sel    (build_sel),
        .slot_right   (slot_right),
        .parent_addr  (parent_addr),
        .token_q      (token_q),
        .data_q       (data_q),
        .new_addr     (alloc_addr),
        .node_word    (node_word),
        .rd_token     (rd_token),
        .rd_left      (rd_left),
        .rd_right     (rd_right),
        .rd_has_left  (rd_has_left),
        .rd_has_right (rd_has_right)
    );

    node_mem_port u_port (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .mem          (mem_if.port),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_wr       (mem_wr),
        .mem_rd       (mem_rd),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_ready (mem_rd_ready),
        .mem_rd_data  (mem_rd_data)
    );

    // Emptying the tree only counts while the engine is idle
    node_alloc #(
        .MAX_NODES (MAX_NODES)
    ) u_alloc (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .tree_emptied (tree_emptied && req_ready),
        .commit       (alloc_commit),
        .tree_ready   (tree_ready),
        .alloc_addr   (alloc_addr),
        .full         (alloc_full)
    );

endmodule

/* tests/bster_insert_asserts.sv */
// ----------------------------------------------------------------------
// Handshake checks on the ports of the tree insert engine
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module bster_insert_asserts (
    input logic              aclk,
    input logic              aresetn,
    input logic              req_valid,
    input logic              req_ready,
    input bster_pkg::cmd_t   req_cmd,
    input logic              cpl_valid,
    input logic              cpl_ready,
    input logic              cpl_status,
    input logic              mem_valid,
    input logic              mem_ready,
    input logic              mem_wr,
    input logic              mem_rd,
    input bster_pkg::addr_t  mem_addr,
    input bster_pkg::node_t  mem_wr_data,
    input logic              mem_rd_valid,
    input logic              mem_rd_ready
);

    int fail_count = 0;

    // Memory request held until mem_ready
    mem_held: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_wr) && $stable(mem_rd) &&
            $stable(mem_addr) && $stable(mem_wr_data))
        else begin
            $error("memory request changed before mem_ready");
            fail_count++;
        end

    cpl_held: assert property (@(posedge aclk) disable iff (!aresetn)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl_status))
        else begin
            $error("completion dropped or changed before cpl_ready");
            fail_count++;
        end

    // ------------------------------------------------------------------
    // Read data phase
    // ------------------------------------------------------------------
    rd_ready_start: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_valid && mem_ready && mem_rd |=> mem_rd_ready)
        else begin
            $error("mem_rd_ready missing after an accepted read");
            fail_count++;
        end

    rd_ready_end: assert property (@(posedge aclk) disable iff (!aresetn)
        mem_rd_ready && mem_rd_valid |=> !mem_rd_ready)
        else begin
            $error("mem_rd_ready still high after mem_rd_valid");
            fail_count++;
        end

    rd_ready_cause: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(mem_rd_ready) |-> $past(mem_valid && mem_ready && mem_rd))
        else begin
            $error("mem_rd_ready rose without an accepted read");
            fail_count++;
        end

    // One request in flight, released only by the completion handshake
    req_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        (req_valid && req_ready) || (!req_ready && !(cpl_valid && cpl_ready)) |=> !req_ready)
        else begin
            $error("req_ready high while a request is in flight");
            fail_count++;
        end

    bad_cmd: assert property (@(posedge aclk) disable iff (!aresetn)
        req_valid && req_ready && req_cmd != bster_pkg::CMD_INSERT_TOKEN |=>
            cpl_valid && cpl_status)
        else begin
            $error("unknown command not refused on the next cycle");
            fail_count++;
        end

endmodule

bind bster_insert_top bster_insert_asserts u_asserts (.*);

/* tests/tb_bster_insert.sv */
// ----------------------------------------------------------------------
// Testbench of the tree insert engine: node RAM model, reference tree
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_bster_insert;

    localparam int MAX_NODES       = 8;
    localparam int N_INSERTS       = MAX_NODES + 4;
    localparam int WATCHDOG_CYCLES = N_INSERTS * MAX_NODES * 40 + 2000;

    logic aclk;
    logic aresetn;
    logic req_valid;
    logic req_ready;
    bster_pkg::cmd_t req_cmd;
    bster_pkg::token_t req_token;
    bster_pkg::payload_t req_data;
    logic cpl_valid;
    logic cpl_ready = 1'b0;
    logic cpl_status;
    logic tree_emptied;
    logic mem_valid;
    logic mem_ready = 1'b0;
    logic mem_wr;
    logic mem_rd;
    bster_pkg::addr_t mem_addr;
    bster_pkg::node_t mem_wr_data;
    logic mem_rd_valid = 1'b0;
    logic mem_rd_ready;
    bster_pkg::node_t mem_rd_data = '0;

    logic [31:0] stim_seed = 32'd21872;
    logic [31:0] bus_seed  = 32'd21872;
    bster_pkg::node_t ram [0:255];
    bster_pkg::addr_t wr_addr_log [$];
    bster_pkg::node_t wr_data_log [$];
    int mem_valid_cycles = 0;
    int cpl_count = 0;
    logic last_status = 1'b0;

    // Reference tree, one entry per node address
    bster_pkg::token_t   ref_tok [0:255];
    bster_pkg::payload_t ref_pay [0:255];
    bster_pkg::addr_t    ref_left [0:255];
    bster_pkg::addr_t    ref_right [0:255];
    bster_pkg::addr_t    ref_par [0:255];
    bster_pkg::info_t    ref_info [0:255];
    int ref_count = 0;
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    bster_insert_top #(.MAX_NODES(MAX_NODES)) uut (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ------------------------------------------------------------------
    // Node RAM with random stalls, completion back-pressure
    // ------------------------------------------------------------------
    always @(posedge aclk) begin
        bus_seed = lcg_step(bus_seed);
        mem_ready    <= (bus_seed[30:29] != 2'b00);
        mem_rd_valid <= bus_seed[28];
        cpl_ready    <= bus_seed[27];
        if (mem_valid && mem_ready) begin
            if (mem_wr) begin
                ram[mem_addr] <= mem_wr_data;
                wr_addr_log.push_back(mem_addr);
                wr_data_log.push_back(mem_wr_data);
            end else begin
                mem_rd_data <= ram[mem_addr];
            end
        end
        if (mem_valid) begin
            mem_valid_cycles <= mem_valid_cycles + 1;
        end
        if (cpl_valid && cpl_ready) begin
            cpl_count   <= cpl_count + 1;
            last_status <= cpl_status;
        end
    end

    function automatic bster_pkg::node_t ref_node(input bster_pkg::addr_t a);
        return {ref_pay[a], ref_left[a], ref_right[a], ref_par[a], ref_tok[a], ref_info[a]};
    endfunction

    task automatic next_stimulus(output bster_pkg::token_t tok, output bster_pkg::payload_t pay);
        stim_seed = lcg_step(stim_seed);
        tok = stim_seed[30:23];
        pay = stim_seed[22:7];
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, test_errors);
        end else begin
            $display("test %s: ok", name);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic send_request(input bster_pkg::cmd_t cmd, input bster_pkg::token_t tok,
                                input bster_pkg::payload_t pay);
        int start;
        start = cpl_count;
        @(posedge aclk);
        req_valid <= 1'b1;
        req_cmd   <= cmd;
        req_token <= tok;
        req_data  <= pay;
        do @(posedge aclk); while (!req_ready);
        req_valid <= 1'b0;
        while (cpl_count == start) @(posedge aclk);
    endtask

    // Walks the reference tree, smaller or equal tokens go left
    task automatic insert_and_check(input bster_pkg::token_t tok, input bster_pkg::payload_t pay);
        bster_pkg::addr_t cur;
        bster_pkg::addr_t k;
        logic go_right;
        logic found;
        wr_addr_log.delete();
        wr_data_log.delete();
        k = bster_pkg::addr_t'(ref_count);
        send_request(bster_pkg::CMD_INSERT_TOKEN, tok, pay);
        check_value("cpl_status", 64'(last_status), 64'd0);
        ref_tok[k]   = tok;
        ref_pay[k]   = pay;
        ref_left[k]  = '0;
        ref_right[k] = '0;
        ref_par[k]   = bster_pkg::ROOT_ADDR;
        ref_info[k]  = '0;
        if (ref_count == 0) begin
            ref_info[k][bster_pkg::INFO_ROOT] = 1'b1;
            check_value("write count", 64'(wr_addr_log.size()), 64'd1);
            if (wr_addr_log.size() == 1) begin
                check_value("mem_addr", 64'(wr_addr_log[0]), 64'd0);
                check_value("mem_wr_data", 64'(wr_data_log[0]), 64'(ref_node(k)));
            end
        end else begin
            cur = bster_pkg::ROOT_ADDR;
            found = 1'b0;
            go_right = 1'b0;
            while (!found) begin
                go_right = (tok > ref_tok[cur]);
                if (!go_right && ref_info[cur][bster_pkg::INFO_HAS_LEFT]) begin
                    cur = ref_left[cur];
                end else if (go_right && ref_info[cur][bster_pkg::INFO_HAS_RIGHT]) begin
                    cur = ref_right[cur];
                end else begin
                    found = 1'b1;
                end
            end
            if (go_right) begin
                ref_right[cur] = k;
                ref_info[cur][bster_pkg::INFO_HAS_RIGHT] = 1'b1;
            end else begin
                ref_left[cur] = k;
                ref_info[cur][bster_pkg::INFO_HAS_LEFT] = 1'b1;
                ref_info[k][bster_pkg::INFO_IS_LEFT] = 1'b1;
            end
            ref_par[k] = cur;
            check_value("write count", 64'(wr_addr_log.size()), 64'd2);
            if (wr_addr_log.size() == 2) begin
                check_value("parent mem_addr", 64'(wr_addr_log[0]), 64'(cur));
                check_value("parent mem_wr_data", 64'(wr_data_log[0]), 64'(ref_node(cur)));
                check_value("child mem_addr", 64'(wr_addr_log[1]), 64'(k));
                check_value("child mem_wr_data", 64'(wr_data_log[1]), 64'(ref_node(k)));
            end
        end
        ref_count++;
    endtask

    task automatic refused_check(input bster_pkg::cmd_t cmd, input bster_pkg::token_t tok,
                                 input bster_pkg::payload_t pay);
        int valid_start;
        valid_start = mem_valid_cycles;
        send_request(cmd, tok, pay);
        check_value("cpl_status", 64'(last_status), 64'd1);
        check_value("mem_valid cycles", 64'(mem_valid_cycles - valid_start), 64'd0);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        bster_pkg::token_t tok;
        bster_pkg::payload_t pay;
        bster_pkg::token_t root_tok;
        int asrt_fails;
        for (int i = 0; i < 256; i++) begin
            ram[i] <= {7{bster_pkg::addr_t'(i)}};
        end
        aresetn      <= 1'b0;
        req_valid    <= 1'b0;
        req_cmd      <= '0;
        req_token    <= '0;
        req_data     <= '0;
        tree_emptied <= 1'b0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (2) @(posedge aclk);

        next_stimulus(tok, pay);
        root_tok = tok;
        insert_and_check(tok, pay);
        end_test("root insert");

        for (int i = 1; i < MAX_NODES; i++) begin
            next_stimulus(tok, pay);
            // Repeat the root token once to take the equal case
            if (i == 3) begin
                tok = root_tok;
            end
            insert_and_check(tok, pay);
        end
        end_test("child inserts");

        next_stimulus(tok, pay);
        refused_check(bster_pkg::CMD_INSERT_TOKEN, tok, pay);
        end_test("insert into full tree");

        @(posedge aclk);
        tree_emptied <= 1'b1;
        @(posedge aclk);
        tree_emptied <= 1'b0;
        ref_count = 0;
        next_stimulus(tok, pay);
        insert_and_check(tok, pay);
        end_test("insert after tree_emptied");

        next_stimulus(tok, pay);
        refused_check(8'h07, tok, pay);
        next_stimulus(tok, pay);
        insert_and_check(tok, pay);
        end_test("unknown command");

        asrt_fails = uut.u_asserts.fail_count;
        $display("tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
hw/bster_pkg.sv
hw/node_mem_if.sv
hw/node_alloc.sv
hw/node_format.sv
hw/node_mem_port.sv
hw/insert_ctrl.sv
hw/bster_insert_top.sv
tests/bster_insert_asserts.sv
tests/tb_bster_insert.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_bster_insert
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
